// ==== src/aluPkg.sv ====
// ALU package
// Shared widths, word types and the opcode set of the accumulator ALU

package aluPkg;

	// ==============================
	// Widths
	// ==============================
	localparam int WORD_W = 16; // Operand width
	localparam int ACC_W  = 32; // Accumulator width, two words

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ACC_W-1:0]  acc_t;

	// ==============================
	// Opcodes
	// ==============================
	// Code 14 has no name and acts as a no-op
	typedef enum logic [3:0]
	{
		OP_NOP    = 4'd0,
		OP_RESET  = 4'd1,
		OP_ADD    = 4'd2,
		OP_SUB    = 4'd3,
		OP_MUL    = 4'd4,
		OP_DIV    = 4'd5,
		OP_MOD    = 4'd6,
		OP_AND    = 4'd7,
		OP_NAND   = 4'd8,
		OP_NOR    = 4'd9,
		OP_NOT    = 4'd10,
		OP_OR     = 4'd11,
		OP_XNOR   = 4'd12,
		OP_XOR    = 4'd13,
		OP_PRESET = 4'd15
	} opcode_e;

endpackage

// ==== src/cmdLatch.sv ====
// Command register
// Samples the command strobe each cycle and holds opcode and operand of the last command

`timescale 1ns/1ps

module cmdLatch
(
	input  logic            clk,
	input  logic            rstN,
	input  logic            cmdValid,
	input  aluPkg::opcode_e opcode,
	input  aluPkg::word_t   operand,
	output logic            opValid,
	output aluPkg::opcode_e opReg,
	output aluPkg::word_t   operandReg
);
	import aluPkg::*;

	// Strobe, one cycle per sampled command
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			opValid <= 1'b0;
		else
			opValid <= cmdValid;
	end

	// Payload only moves on a new command
	always_ff @(posedge clk)
	begin
		if (cmdValid)
		begin
			opReg      <= opcode;
			operandReg <= operand;
		end
	end

endmodule

// ==== src/arrayMultiplier.sv ====
// Array multiplier
// Unsigned 16x16 product from rows of partial-product additions

`timescale 1ns/1ps

module arrayMultiplier
(
	input  aluPkg::word_t multiplicand,
	input  aluPkg::word_t multiplier,
	output aluPkg::acc_t  product
);
	import aluPkg::*;

	word_t             partial [WORD_W];   // ANDed rows
	logic [WORD_W:0]   rowSum  [WORD_W-1]; // Carry out on top

	// ==============================
	// Partial products
	// ==============================
	for (genvar r = 0; r < WORD_W; r++)
	begin : g_pp
		assign partial[r] = multiplicand & {WORD_W{multiplier[r]}};
	end

	// ==============================
	// Adder rows
	// ==============================
	// Each row adds the next partial product to the upper bits of the row above,
	// and its low sum bit is final
	for (genvar r = 0; r < WORD_W-1; r++)
	begin : g_row
		word_t augend;

		if (r == 0)
			assign augend = {1'b0, partial[0][WORD_W-1:1]};
		else
			assign augend = rowSum[r-1][WORD_W:1]; // Carry and upper sum

		assign rowSum[r]    = {1'b0, augend} + {1'b0, partial[r+1]};
		assign product[r+1] = rowSum[r][0];
	end

	assign product[0] = partial[0][0];
	assign product[ACC_W-1:WORD_W] = rowSum[WORD_W-2][WORD_W:1]; // Last row gives the top word

endmodule

// ==== src/executeUnit.sv ====
// Execute unit
// Combinational value and flags of the registered command against the low accumulator word

`timescale 1ns/1ps

module executeUnit
(
	input  aluPkg::opcode_e opReg,
	input  aluPkg::word_t   operandReg,
	input  aluPkg::acc_t    accValue,
	output aluPkg::acc_t    execValue,
	output logic            execCarry,
	output logic            execDivZero
);
	import aluPkg::*;

	word_t           accLow;
	logic [WORD_W:0] sumWide;
	word_t           diffWord;
	acc_t            mulProduct;
	logic            divisorZero;

	assign accLow      = accValue[WORD_W-1:0];
	assign sumWide     = {1'b0, accLow} + {1'b0, operandReg};
	assign diffWord    = accLow - operandReg; // Wraps modulo 2^16
	assign divisorZero = (operandReg == '0);

	arrayMultiplier i_mult
	(
		.multiplicand (accLow),
		.multiplier   (operandReg),
		.product      (mulProduct)
	);

	// ==============================
	// Opcode select
	// ==============================
	always_comb
	begin
		execValue   = accValue; // Hold for nop, reset, preset
		execCarry   = 1'b0;
		execDivZero = 1'b0;

		case (opReg)
			OP_ADD:
			begin
				execValue = acc_t'(sumWide[WORD_W-1:0]);
				execCarry = sumWide[WORD_W];
			end
			OP_SUB:
			begin
				execValue = acc_t'(diffWord);
				execCarry = (accLow < operandReg); // Borrow
			end
			OP_MUL:  execValue = mulProduct;
			OP_DIV, OP_MOD:
			begin
				if (divisorZero)
				begin
					execValue   = '0;
					execDivZero = 1'b1;
				end
				else if (opReg == OP_DIV)
					execValue = acc_t'(accLow / operandReg);
				else
					execValue = acc_t'(accLow % operandReg);
			end
			OP_AND:  execValue = acc_t'(accLow & operandReg);
			OP_NAND: execValue = {{WORD_W{1'b0}}, ~(accLow & operandReg)};
			OP_NOR:  execValue = {{WORD_W{1'b0}}, ~(accLow | operandReg)};
			OP_NOT:  execValue = {{WORD_W{1'b0}}, ~accLow}; // Single operand
			OP_OR:   execValue = acc_t'(accLow | operandReg);
			OP_XNOR: execValue = {{WORD_W{1'b0}}, ~(accLow ^ operandReg)};
			OP_XOR:  execValue = acc_t'(accLow ^ operandReg);
			default: ;
		endcase
	end

endmodule

// ==== src/accumOut.sv ====
// Accumulator register
// Applies each command to the accumulator, keeps the error flags and pulses done

`timescale 1ns/1ps

module accumOut
(
	input  logic            clk,
	input  logic            rstN,
	input  logic            opValid,
	input  aluPkg::opcode_e opReg,
	input  aluPkg::acc_t    execValue,
	input  logic            execCarry,
	input  logic            execDivZero,
	output aluPkg::acc_t    accValue,
	output logic            done,
	output logic            carryErr,
	output logic            divErr
);
	import aluPkg::*;

	logic holdCmd;

	// Nop and the unnamed code 14 leave the accumulator alone
	assign holdCmd = (opReg == OP_NOP) || (opReg == 4'd14);

	// ==============================
	// Accumulator and flags
	// ==============================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			accValue <= '0;
			done     <= 1'b0;
			carryErr <= 1'b0;
			divErr   <= 1'b0;
		end
		else
		begin
			done <= opValid; // One pulse per applied command

			if (opValid)
			begin
				carryErr <= 1'b0;
				divErr   <= 1'b0;

				if (opReg == OP_RESET)
					accValue <= '0;
				else if (opReg == OP_PRESET)
					accValue <= acc_t'(1);
				else if (execDivZero)
					divErr <= 1'b1; // Accumulator kept
				else if (!holdCmd)
				begin
					accValue <= execValue;
					carryErr <= execCarry; // Low outside add and sub
				end
			end
		end
	end

endmodule

// ==== src/aluTop.sv ====
// Accumulator ALU top
// Command register, execute unit and accumulator register in a two-edge pipeline

`timescale 1ns/1ps

module aluTop
(
	input  logic            clk,
	input  logic            rstN,
	input  logic            cmdValid,
	input  aluPkg::opcode_e opcode,
	input  aluPkg::word_t   operand,
	output aluPkg::acc_t    result,
	output logic            done,
	output logic            carryErr,
	output logic            divErr
);
	import aluPkg::*;

	logic    opValid;
	opcode_e opReg;
	word_t   operandReg;
	acc_t    execValue;
	logic    execCarry;
	logic    execDivZero;

	cmdLatch i_cmd
	(
		.clk        (clk),
		.rstN       (rstN),
		.cmdValid   (cmdValid),
		.opcode     (opcode),
		.operand    (operand),
		.opValid    (opValid),
		.opReg      (opReg),
		.operandReg (operandReg)
	);

	executeUnit i_exec
	(
		.opReg       (opReg),
		.operandReg  (operandReg),
		.accValue    (result),     // Feedback from the accumulator
		.execValue   (execValue),
		.execCarry   (execCarry),
		.execDivZero (execDivZero)
	);

	accumOut i_acc
	(
		.clk         (clk),
		.rstN        (rstN),
		.opValid     (opValid),
		.opReg       (opReg),
		.execValue   (execValue),
		.execCarry   (execCarry),
		.execDivZero (execDivZero),
		.accValue    (result),
		.done        (done),
		.carryErr    (carryErr),
		.divErr      (divErr)
	);

endmodule

// ==== tests/aluTb_assert.sv ====
// Accumulator register checks
// Done timing and flag exclusivity, bound into accumOut

`timescale 1ns/1ps

module aluTb_assert
(
	input logic clk,
	input logic rstN,
	input logic opValid,
	input logic done,
	input logic carryErr,
	input logic divErr
);

	// Done stays low while reset is held
	doneInReset: assert property (@(posedge clk) !rstN |-> !done)
		else $error("done high during reset");

	// One done pulse exactly one cycle after each strobe
	doneAfterValid: assert property (@(posedge clk) disable iff (!rstN) opValid |=> done)
		else $error("done missing one cycle after opValid");

	noSpuriousDone: assert property (@(posedge clk) disable iff (!rstN) !opValid |=> !done)
		else $error("done pulse without a preceding opValid");

	flagsExclusive: assert property (@(posedge clk) disable iff (!rstN) !(carryErr && divErr))
		else $error("carryErr and divErr high together");

endmodule

bind accumOut aluTb_assert i_assert
(
	.clk      (clk),
	.rstN     (rstN),
	.opValid  (opValid),
	.done     (done),
	.carryErr (carryErr),
	.divErr   (divErr)
);

// ==== tests/aluTb.sv ====
// Accumulator ALU testbench
// Seeded random commands against a reference model, checked every cycle

`timescale 1ns/1ps

module aluTb;
	import aluPkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int RANDOM_CYCLES = 600;
	localparam int DONE_TIMEOUT  = 20;

	logic    clk;
	logic    rstN;
	logic    cmdValid;
	opcode_e opcode;
	word_t   operand;
	acc_t    result;
	logic    done;
	logic    carryErr;
	logic    divErr;

	// Reference model state
	acc_t modelAcc;
	logic modelCarry;
	logic modelDiv;

	// Commands in flight, oldest first
	opcode_e opQ[$];
	word_t   operandQ[$];
	int      edgeQ[$];

	int          edgeCount    = 0;
	int          checkedCount = 0;
	int          carryCount   = 0;
	int          divZeroCount = 0;
	logic [31:0] rngState     = 32'd28;
	bit          failReported = 1'b0;
	bit          runPassed    = 1'b0;

	aluTop i_dut
	(
		.clk      (clk),
		.rstN     (rstN),
		.cmdValid (cmdValid),
		.opcode   (opcode),
		.operand  (operand),
		.result   (result),
		.done     (done),
		.carryErr (carryErr),
		.divErr   (divErr)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// ==============================
	// Helpers
	// ==============================
	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic acc_t zeroExt(input word_t w);
		return {{WORD_W{1'b0}}, w};
	endfunction

	task automatic failRun(input string why);
		failReported = 1'b1;
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic compareAcc(input string name, input acc_t expected, input acc_t actual);
		if (actual !== expected)
			failRun($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
	endtask

	task automatic compareFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			failRun($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
	endtask

	// ==============================
	// Reference model
	// ==============================
	task automatic applyModel(input opcode_e op, input word_t val);
		word_t           accLow;
		logic [WORD_W:0] sum;

		accLow     = modelAcc[WORD_W-1:0];
		modelCarry = 1'b0;
		modelDiv   = 1'b0;
		case (op)
			OP_RESET:  modelAcc = '0;
			OP_PRESET: modelAcc = acc_t'(1);
			OP_ADD:
			begin
				sum        = {1'b0, accLow} + {1'b0, val};
				modelAcc   = zeroExt(sum[WORD_W-1:0]);
				modelCarry = sum[WORD_W]; // Carry out
			end
			OP_SUB:
			begin
				modelAcc   = zeroExt(accLow - val);
				modelCarry = (accLow < val);
			end
			OP_MUL: modelAcc = zeroExt(accLow) * zeroExt(val);
			OP_DIV, OP_MOD:
			begin
				if (val == '0)
				begin
					modelDiv = 1'b1; // Accumulator holds
					divZeroCount++;
				end
				else if (op == OP_DIV)
					modelAcc = zeroExt(accLow / val);
				else
					modelAcc = zeroExt(accLow % val);
			end
			OP_AND:  modelAcc = zeroExt(accLow & val);
			OP_NAND: modelAcc = zeroExt(~(accLow & val));
			OP_NOR:  modelAcc = zeroExt(~(accLow | val));
			OP_NOT:  modelAcc = zeroExt(~accLow);
			OP_OR:   modelAcc = zeroExt(accLow | val);
			OP_XNOR: modelAcc = zeroExt(~(accLow ^ val));
			OP_XOR:  modelAcc = zeroExt(accLow ^ val);
			default: ; // NOP and code 14 hold
		endcase
		if (modelCarry)
			carryCount++;
	endtask

	// Expected done when the oldest command was sampled one edge ago
	task automatic checkCycle();
		logic    expectDone;
		opcode_e op;
		word_t   val;

		expectDone = 1'b0;
		if (!rstN)
		begin
			modelAcc   = '0;
			modelCarry = 1'b0;
			modelDiv   = 1'b0;
		end
		else
			expectDone = (edgeQ.size() > 0) && (edgeQ[0] + 1 == edgeCount);
		compareFlag("done", expectDone, done);
		if (expectDone)
		begin
			op  = opQ.pop_front();
			val = operandQ.pop_front();
			void'(edgeQ.pop_front());
			applyModel(op, val);
			checkedCount++;
		end
		compareAcc("result", modelAcc, result);
		compareFlag("carryErr", modelCarry, carryErr);
		compareFlag("divErr", modelDiv, divErr);
	endtask

	// Inputs are stable at the edge, driven 1 ns later
	always @(posedge clk)
	begin
		edgeCount = edgeCount + 1;
		if (rstN && cmdValid)
		begin
			opQ.push_back(opcode);
			operandQ.push_back(operand);
			edgeQ.push_back(edgeCount);
		end
	end

	always @(posedge clk)
	begin
		#2;
		checkCycle();
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic waitDone();
		int i;
		bit seen;

		seen = 1'b0;
		for (i = 0; i < DONE_TIMEOUT && !seen; i++)
		begin
			@(posedge clk);
			#1;
			seen = done;
		end
		if (!seen)
			failRun("Timeout: no done pulse after a single command");
	endtask

	task automatic sendCommand(input opcode_e op, input word_t val);
		cmdValid = 1'b1;
		opcode   = op;
		operand  = val;
		@(posedge clk);
		#1;
		cmdValid = 1'b0;
		waitDone();
	endtask

	task automatic drainQueue();
		int i;

		for (i = 0; i < DONE_TIMEOUT && edgeQ.size() > 0; i++)
		begin
			@(posedge clk);
			#1;
		end
		if (edgeQ.size() > 0)
			failRun("Timeout: commands still outstanding after the stimulus ended");
	endtask

	initial
	begin
		logic [31:0] r;
		int          i;

		rstN     = 1'b0;
		cmdValid = 1'b0;
		opcode   = OP_NOP;
		operand  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Quiet state before any command
		compareAcc("result", '0, result);
		compareFlag("done", 1'b0, done);
		compareFlag("carryErr", 1'b0, carryErr);
		compareFlag("divErr", 1'b0, divErr);

		sendCommand(OP_PRESET, 16'h1234);
		compareAcc("result", acc_t'(1), result);
		sendCommand(OP_RESET, 16'hbeef);
		compareAcc("result", '0, result);

		// Back-to-back random commands, strobe high about 70% of cycles
		for (i = 0; i < RANDOM_CYCLES; i++)
		begin
			r        = nextRand();
			cmdValid = ((r >> 16) % 32'd100) < 32'd70;
			r        = nextRand();
			opcode   = opcode_e'(r[27:24]);
			r        = nextRand();
			operand  = (r[31:29] == 3'd0) ? '0 : r[23:8]; // One in eight is zero
			@(posedge clk);
			#1;
		end
		cmdValid = 1'b0;
		drainQueue();

		$display("Checked %0d commands, %0d carries, %0d zero divides",
			checkedCount, carryCount, divZeroCount);
		if (divZeroCount == 0 || carryCount == 0)
			failRun("Random run never produced a carry or a divide by zero");
		else
		begin
			runPassed = 1'b1;
			$display("TESTS PASSED");
			$finish;
		end
	end

	// Run cut short elsewhere, such as by a failed assertion
	final
	begin
		if (!runPassed && !failReported)
			$display("TESTS FAILED");
	end

endmodule

// ==== flist.f ====
src/aluPkg.sv
src/cmdLatch.sv
src/arrayMultiplier.sv
src/executeUnit.sv
src/accumOut.sv
src/aluTop.sv
tests/aluTb_assert.sv
tests/aluTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the accumulator ALU testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module aluTb \
	--Mdir obj_dir -o aluSim -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/aluSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi
exit 0
